/* verilog/stopwatch_pkg.sv */
`default_nettype none

package stopwatch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Timing
    //////////////////////////////////////////////////////////////////////

    // Enabled clock cycles per displayed second
    localparam int TICK_CYCLES = 10;
    localparam int TICK_W = $clog2(TICK_CYCLES);

    // Page select
    localparam int PAGE_W = 4;
    localparam logic [PAGE_W-1:0] STOPWATCH_PAGE = 4'd5;

    // Count saturates at LIMIT_MINUTES:00
    localparam logic [3:0] LIMIT_MINUTES = 4'd4;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [3:0] minutes;
        logic [2:0] tens;
        logic [3:0] ones;
    } elapsed_t;

    typedef enum logic [1:0] {
        CLEARED,
        RUNNING,
        PAUSED,
        AT_LIMIT
    } run_state_t;

endpackage

`default_nettype wire

/* verilog/display_pkg.sv */
`default_nettype none

package display_pkg;

    localparam int COORD_W = 7;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } pixel_t;

    typedef logic [15:0] rgb565_t;

    //////////////////////////////////////////////////////////////////////
    // Glyph geometry
    //////////////////////////////////////////////////////////////////////

    localparam int GLYPH_SCALE = 2;
    localparam int GLYPH_COLS = 5;
    localparam int GLYPH_ROWS = 7;
    localparam int GLYPH_W = GLYPH_COLS * GLYPH_SCALE;
    localparam int GLYPH_H = GLYPH_ROWS * GLYPH_SCALE;

    localparam logic [COORD_W-1:0] GLYPH_TOP = 7'd24;
    localparam logic [COORD_W-1:0] MIN_X = 7'd30;
    localparam logic [COORD_W-1:0] TENS_X = 7'd48;
    localparam logic [COORD_W-1:0] ONES_X = 7'd62;

    // Colon dots are GLYPH_SCALE square, starting at these rows
    localparam logic [COORD_W-1:0] COLON_X0 = 7'd43;
    localparam logic [COORD_W-1:0] COLON_ROWS [2] = '{7'd27, 7'd33};

    // Row 0 at top, bit 4 is the leftmost column
    localparam logic [GLYPH_COLS-1:0] FONT_5X7 [10][GLYPH_ROWS] = '{
        '{5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b01110},
        '{5'b00100, 5'b11100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b11111},
        '{5'b01110, 5'b10001, 5'b00010, 5'b00100, 5'b01000, 5'b10000, 5'b11111},
        '{5'b01110, 5'b10001, 5'b00001, 5'b00110, 5'b00001, 5'b10001, 5'b01110},
        '{5'b10000, 5'b10010, 5'b10010, 5'b10010, 5'b11111, 5'b00010, 5'b00010},
        '{5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b11110},
        '{5'b01111, 5'b10000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110},
        '{5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b00100, 5'b00100, 5'b00100},
        '{5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110},
        '{5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b00001, 5'b00001, 5'b01110}
    };

    //////////////////////////////////////////////////////////////////////
    // Colour themes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MONO,
        RED_ON_YELLOW,
        BLUE_ON_GREEN,
        BLACK_ON_MAGENTA
    } theme_t;

    // Indexed by theme_t
    localparam rgb565_t THEME_FG [4] = '{16'hFFFF, 16'hF800, 16'h001F, 16'h0000};
    localparam rgb565_t THEME_BG [4] = '{16'h0000, 16'hFFE0, 16'h07E0, 16'hF81F};

endpackage

`default_nettype wire

/* verilog/second_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

module second_prescaler import stopwatch_pkg::*; (
    input  logic CLOCK,
    input  logic rst_n,
    input  logic count_en,
    input  logic clear_time,
    output logic sec_tick
);

    logic [TICK_W-1:0] count;

    // Count holds while disabled so a paused second is not lost
    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            sec_tick <= 1'b0;
        end else if (clear_time) begin
            count    <= '0;
            sec_tick <= 1'b0;
        end else if (count_en && count == TICK_W'(TICK_CYCLES - 1)) begin
            count    <= '0;
            sec_tick <= 1'b1;
        end else begin
            if (count_en)
                count <= count + 1'b1;
            sec_tick <= 1'b0;
        end
    end

    a_tick_single : assert property (
        @(posedge CLOCK) disable iff (!rst_n) sec_tick |=> !sec_tick
    );

endmodule

`default_nettype wire

/* verilog/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control import stopwatch_pkg::*; (
    input  logic              CLOCK,
    input  logic              rst_n,
    input  logic              run,
    input  logic              clear,
    input  logic [PAGE_W-1:0] page,
    input  logic              at_limit,
    output logic              count_en,
    output logic              clear_time
);

    run_state_t state;
    run_state_t next_state;
    logic       page_hit;

    // Switches only act on the stopwatch page
    assign page_hit = (page == STOPWATCH_PAGE);

    always_comb begin
        next_state = state;
        if (page_hit && clear) begin
            next_state = CLEARED;
        end else begin
            case (state)
                CLEARED, PAUSED: begin
                    if (page_hit && run)
                        next_state = RUNNING;
                end
                RUNNING: begin
                    if (at_limit)
                        next_state = AT_LIMIT;
                    else if (page_hit && !run)
                        next_state = PAUSED;
                end
                // Only clear leaves
                AT_LIMIT: next_state = AT_LIMIT;
                default:  next_state = CLEARED;
            endcase
        end
    end

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CLEARED;
            count_en   <= 1'b0;
            clear_time <= 1'b0;
        end else begin
            state      <= next_state;
            count_en   <= (next_state == RUNNING);
            clear_time <= page_hit && clear;
        end
    end

    // Counting stops one cycle after the limit is seen
    a_no_count_at_limit : assert property (
        @(posedge CLOCK) disable iff (!rst_n) at_limit && count_en |=> !count_en
    );

    a_clear_blocks_count : assert property (
        @(posedge CLOCK) disable iff (!rst_n) !(count_en && clear_time)
    );

endmodule

`default_nettype wire

/* verilog/elapsed_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module elapsed_counter import stopwatch_pkg::*; (
    input  logic     CLOCK,
    input  logic     rst_n,
    input  logic     sec_tick,
    input  logic     clear_time,
    output elapsed_t elapsed,
    output logic     at_limit
);

    //////////////////////////////////////////////////////////////////////
    // Saturation
    //////////////////////////////////////////////////////////////////////

    assign at_limit = (elapsed.minutes == LIMIT_MINUTES) &&
                      (elapsed.tens == 3'd0) &&
                      (elapsed.ones == 4'd0);

    //////////////////////////////////////////////////////////////////////
    // BCD-style digit chain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            elapsed <= '0;
        end else if (clear_time) begin
            elapsed <= '0;
        end else if (sec_tick && !at_limit) begin
            if (elapsed.ones == 4'd9) begin
                elapsed.ones <= 4'd0;
                // Carry out of the tens digit at 59 seconds
                if (elapsed.tens == 3'd5) begin
                    elapsed.tens    <= 3'd0;
                    elapsed.minutes <= elapsed.minutes + 4'd1;
                end else begin
                    elapsed.tens <= elapsed.tens + 3'd1;
                end
            end else begin
                elapsed.ones <= elapsed.ones + 4'd1;
            end
        end
    end

    a_digits_in_range : assert property (
        @(posedge CLOCK) disable iff (!rst_n)
            elapsed.tens <= 3'd5 && elapsed.ones <= 4'd9
    );

endmodule

`default_nettype wire

/* verilog/time_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module time_renderer import stopwatch_pkg::*, display_pkg::*; (
    input  logic     CLOCK,
    input  logic     rst_n,
    input  pixel_t   pixel,
    input  elapsed_t elapsed,
    input  logic [2:0] theme_sw,
    output rgb565_t  oled_data
);

    logic [3:0]            digit;
    logic [COORD_W-1:0]    dx;
    logic [COORD_W-1:0]    dy;
    logic [2:0]            col_idx;
    logic [2:0]            row_idx;
    logic                  in_cell;
    logic                  in_rows;
    logic [GLYPH_COLS-1:0] glyph_row;
    logic                  colon_on;
    logic                  pixel_on;
    theme_t                theme;

    function automatic logic in_band(
        input logic [COORD_W-1:0] coord,
        input logic [COORD_W-1:0] start,
        input int                 len
    );
        return (coord >= start) && (int'(coord) < int'(start) + len);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Digit cell lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        digit   = 4'd0;
        dx      = '0;
        in_cell = 1'b1;
        if (in_band(pixel.x, MIN_X, GLYPH_W)) begin
            digit = elapsed.minutes;
            dx    = pixel.x - MIN_X;
        end else if (in_band(pixel.x, TENS_X, GLYPH_W)) begin
            digit = {1'b0, elapsed.tens};
            dx    = pixel.x - TENS_X;
        end else if (in_band(pixel.x, ONES_X, GLYPH_W)) begin
            digit = elapsed.ones;
            dx    = pixel.x - ONES_X;
        end else begin
            in_cell = 1'b0;
        end
    end

    assign dy      = pixel.y - GLYPH_TOP;
    assign in_rows = in_band(pixel.y, GLYPH_TOP, GLYPH_H);

    // Font is drawn scaled, so each font cell covers a square of pixels
    assign col_idx = 3'(dx / GLYPH_SCALE);
    assign row_idx = 3'(dy / GLYPH_SCALE);

    always_comb begin
        glyph_row = '0;
        if (in_cell && in_rows)
            glyph_row = FONT_5X7[digit][row_idx];
    end

    assign colon_on = in_band(pixel.x, COLON_X0, GLYPH_SCALE) &&
                      (in_band(pixel.y, COLON_ROWS[0], GLYPH_SCALE) ||
                       in_band(pixel.y, COLON_ROWS[1], GLYPH_SCALE));

    assign pixel_on = glyph_row[GLYPH_COLS - 1 - col_idx] || colon_on;

    //////////////////////////////////////////////////////////////////////
    // Theme and output register
    //////////////////////////////////////////////////////////////////////

    // Lowest switch wins
    always_comb begin
        if (theme_sw[0])
            theme = RED_ON_YELLOW;
        else if (theme_sw[1])
            theme = BLUE_ON_GREEN;
        else if (theme_sw[2])
            theme = BLACK_ON_MAGENTA;
        else
            theme = MONO;
    end

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n)
            oled_data <= '0;
        else
            oled_data <= pixel_on ? THEME_FG[theme] : THEME_BG[theme];
    end

endmodule

`default_nettype wire

/* verilog/stopwatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_top import stopwatch_pkg::*, display_pkg::*; (
    input  logic              CLOCK,
    input  logic              rst_n,
    input  logic              run,
    input  logic              clear,
    input  logic [PAGE_W-1:0] page,
    input  logic [2:0]        theme_sw,
    input  pixel_t            pixel,
    output rgb565_t           oled_data,
    output elapsed_t          elapsed
);

    logic count_en;
    logic clear_time;
    logic sec_tick;
    logic at_limit;

    run_control u_run_control (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .run        (run),
        .clear      (clear),
        .page       (page),
        .at_limit   (at_limit),
        .count_en   (count_en),
        .clear_time (clear_time)
    );

    second_prescaler u_second_prescaler (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .count_en   (count_en),
        .clear_time (clear_time),
        .sec_tick   (sec_tick)
    );

    elapsed_counter u_elapsed_counter (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .sec_tick   (sec_tick),
        .clear_time (clear_time),
        .elapsed    (elapsed),
        .at_limit   (at_limit)
    );

    time_renderer u_time_renderer (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .pixel      (pixel),
        .elapsed    (elapsed),
        .theme_sw   (theme_sw),
        .oled_data  (oled_data)
    );

endmodule

`default_nettype wire

/* verification/stopwatch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_tb import stopwatch_pkg::*, display_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int MAX_WAIT = 5000;
    localparam int MAX_COMMANDS = 1000;

    logic              CLOCK;
    logic              rst_n;
    logic              run;
    logic              clear;
    logic [PAGE_W-1:0] page;
    logic [2:0]        theme_sw;
    pixel_t            pixel;
    rgb565_t           oled_data;
    elapsed_t          elapsed;

    int checks;
    int check_errors;
    int other_errors;

    stopwatch_top dut (
        .CLOCK     (CLOCK),
        .rst_n     (rst_n),
        .run       (run),
        .clear     (clear),
        .page      (page),
        .theme_sw  (theme_sw),
        .pixel     (pixel),
        .oled_data (oled_data),
        .elapsed   (elapsed)
    );

    always #5 CLOCK = ~CLOCK;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Every step ends on a falling edge, where inputs change
    task automatic wait_cycles(input int n);
        int i;
        if (n > MAX_WAIT) begin
            other_errors++;
            $display("Wait of %0d cycles is longer than the limit of %0d", n, MAX_WAIT);
        end
        i = 0;
        while (i < n && i < MAX_WAIT) begin
            @(negedge CLOCK);
            i++;
        end
    endtask

    task automatic check_time(input string name, input elapsed_t exp_time);
        checks++;
        assert (elapsed == exp_time) else begin
            check_errors++;
            $display("CHECK FAILED %s: expected %0d:%0d%0d, actual %0d:%0d%0d", name,
                     exp_time.minutes, exp_time.tens, exp_time.ones,
                     elapsed.minutes, elapsed.tens, elapsed.ones);
        end
    endtask

    // Output is registered, so one edge passes before the check
    task automatic probe_pixel(input string name, input logic [COORD_W-1:0] x,
                               input logic [COORD_W-1:0] y, input logic [2:0] sw,
                               input rgb565_t exp_rgb);
        pixel.x  = x;
        pixel.y  = y;
        theme_sw = sw;
        wait_cycles(1);
        checks++;
        assert (oled_data == exp_rgb) else begin
            check_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp_rgb, oled_data);
        end
    endtask

    task automatic report_bad_operands(input string cmd);
        other_errors++;
        $display("A %s line in the pattern file has missing or bad operands", cmd);
    endtask

    task automatic run_command(input int fd, input string cmd);
        string            name;
        logic [8*160-1:0] line;
        int               code;
        int               a;
        int               b;
        int               c;
        logic [2:0]       sw;
        rgb565_t          exp_rgb;
        elapsed_t         exp_time;
        if (cmd == "#") begin
            code = $fgets(line, fd);
        end else if (cmd == "SET") begin
            code = $fscanf(fd, "%d %d %d", a, b, c);
            if (code == 3) begin
                run   = a[0];
                clear = b[0];
                page  = PAGE_W'(c);
            end else begin
                report_bad_operands(cmd);
            end
        end else if (cmd == "WAIT") begin
            code = $fscanf(fd, "%d", a);
            if (code == 1)
                wait_cycles(a);
            else
                report_bad_operands(cmd);
        end else if (cmd == "TIME") begin
            code = $fscanf(fd, "%s %d %d %d", name, a, b, c);
            if (code == 4) begin
                exp_time.minutes = a[3:0];
                exp_time.tens    = b[2:0];
                exp_time.ones    = c[3:0];
                check_time(name, exp_time);
            end else begin
                report_bad_operands(cmd);
            end
        end else if (cmd == "PIX") begin
            code = $fscanf(fd, "%s %d %d %b %h", name, a, b, sw, exp_rgb);
            if (code == 5)
                probe_pixel(name, COORD_W'(a), COORD_W'(b), sw, exp_rgb);
            else
                report_bad_operands(cmd);
        end else begin
            other_errors++;
            $display("Unknown command %s in the pattern file", cmd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    code;
        int    lines;
        string cmd;
        CLOCK        = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        clear        = 1'b0;
        page         = STOPWATCH_PAGE;
        theme_sw     = 3'b000;
        pixel        = '0;
        checks       = 0;
        check_errors = 0;
        other_errors = 0;

        wait_cycles(RESET_CYCLES);
        rst_n = 1'b1;

        fd = $fopen("verification/stopwatch_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the pattern file");
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_COMMANDS) begin
                code = $fscanf(fd, "%s", cmd);
                lines++;
                if (code == 1)
                    run_command(fd, cmd);
            end
            if (!$feof(fd)) begin
                other_errors++;
                $display("Pattern file has more than %0d commands", MAX_COMMANDS);
            end
            $fclose(fd);
        end

        if (checks == 0) begin
            other_errors++;
            $display("No checks were run");
        end

        $display("checks %0d, check failures %0d, other errors %0d",
                 checks, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
verilog/stopwatch_pkg.sv
verilog/display_pkg.sv
verilog/second_prescaler.sv
verilog/run_control.sv
verilog/elapsed_counter.sv
verilog/time_renderer.sv
verilog/stopwatch_top.sv
verification/stopwatch_tb.sv

/* verification/stopwatch_patterns.txt */
# SET run clear page | WAIT cycles | TIME name minutes tens ones
# PIX name x y theme_sw(binary) oled_data(hex)
TIME reset 0 0 0
SET 1 0 5
WAIT 11
TIME before_first 0 0 0
WAIT 1
TIME first_second 0 0 1
WAIT 90
TIME tens_carry 0 1 0
WAIT 500
TIME minute_carry 1 0 0
# pause part way into a second, then resume
WAIT 5
SET 0 0 5
WAIT 50
TIME paused 1 0 0
SET 1 0 5
WAIT 4
TIME resume_partial 1 0 0
WAIT 1
TIME resume_keeps 1 0 1
# switches on another page are ignored
SET 0 1 3
WAIT 10
TIME other_page 1 0 2
SET 1 1 5
WAIT 1
TIME clear_latency 1 0 2
WAIT 1
TIME clear_wins 0 0 0
SET 1 0 5
WAIT 2401
TIME before_limit 3 5 9
WAIT 1
TIME at_limit 4 0 0
WAIT 20
TIME limit_holds 4 0 0
# probes on 4:00
PIX min_top_left 30 24 000 FFFF
PIX min_gap 32 24 000 0000
PIX min_bar 38 32 001 F800
PIX tens_hole 52 30 001 FFE0
PIX tens_top 50 24 010 001F
PIX ones_corner 70 36 110 07E0
PIX ones_bottom 68 36 100 0000
PIX colon_gap 43 30 100 F81F
PIX colon_top 43 27 111 F800
PIX colon_bottom 44 34 110 001F
SET 0 1 5
WAIT 2
TIME clear_limit 0 0 0
